/* sources.f */
+incdir+verif
hdl/dac_tpl_pkg.sv
hdl/dds_sine_rom.sv
hdl/dds_two_tone.sv
hdl/pn_source.sv
hdl/dac_channel.sv
hdl/dac_tpl_core.sv
verif/tb_dac_tpl.sv

/* Makefile */
# Verilator build and run for the DAC transport layer testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_dac_tpl
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verif/*.svh)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BINARY) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_dac_tpl_checks.svh */
// Compare tasks for the DAC transport layer testbench.
// Included inside the testbench module, after dac_data and fail_run.
// Each task counts one check and ends the run on a mismatch.
`ifndef TB_DAC_TPL_CHECKS_SVH
`define TB_DAC_TPL_CHECKS_SVH

// One sample word against its expected value
task automatic check_sample(input string name, input dac_tpl_pkg::sample_t got,
                            input dac_tpl_pkg::sample_t exp);
  checks_done++;
  if (got !== exp) begin
    fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  end
endtask

// One control bit, such as a channel enable
task automatic check_bit(input string name, input logic got, input logic exp);
  checks_done++;
  if (got !== exp) begin
    fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  end
endtask

// All lanes of one channel, lane 0 first
task automatic compare_lanes(input int chan,
                             input dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] exp);
  for (int lane = 0; lane < DATA_PATH_WIDTH; lane++) begin
    check_sample($sformatf("dac_data[%0d]", chan * DATA_PATH_WIDTH + lane),
                 dac_data[chan * DATA_PATH_WIDTH + lane], exp[lane]);
  end
endtask

`endif

/* verif/tb_dac_tpl.sv */
// Testbench for the DAC transmit transport layer, two channels of four lanes.
// Directed tests cover reset, DMA pass-through, the fixed pattern,
// PN7/PN15 in both polarities and the two-tone DDS in both formats.
// Run through the Makefile in the project root.

`timescale 1ns/1ps

module tb_dac_tpl;

  localparam int NUM_CHANNELS    = 2;
  localparam int DATA_PATH_WIDTH = 4;
  localparam int WORD_BITS       = DATA_PATH_WIDTH * 16;
  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 5;
  localparam int DMA_CYCLES      = 12;
  localparam int PN_CYCLES       = 20;
  localparam int DDS_CYCLES      = 40;
  localparam real TWO_PI         = 6.283185307179586;

  // Test lengths back to back, then a margin for the watchdog
  localparam int TEST_CYCLES = RESET_CYCLES + 2 * DMA_CYCLES + 4 +
                               2 * (PN_CYCLES + 2) + 2 * (DDS_CYCLES + 3);
  localparam int TIMEOUT_NS  = (TEST_CYCLES + 50) * CLK_PERIOD;

  logic clk;
  logic rst;
  logic sync;
  logic dds_format;
  dac_tpl_pkg::chan_cfg_t [NUM_CHANNELS-1:0]                cfg;
  dac_tpl_pkg::sample_t [NUM_CHANNELS*DATA_PATH_WIDTH-1:0]  dma_data;
  dac_tpl_pkg::sample_t [NUM_CHANNELS*DATA_PATH_WIDTH-1:0]  dac_data;
  logic [NUM_CHANNELS-1:0]                                  enable;
  logic [31:0] rng_state;
  int checks_done;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  `include "tb_dac_tpl_checks.svh"

  dac_tpl_core #(
    .NUM_CHANNELS    (NUM_CHANNELS),
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH)
  ) dac_tpl_core_inst (
    .clk        (clk),
    .rst        (rst),
    .sync       (sync),
    .dds_format (dds_format),
    .cfg        (cfg),
    .dma_data   (dma_data),
    .dac_data   (dac_data),
    .enable     (enable)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    fail_run("Timeout: the tests did not finish before the watchdog expired");
  end

  // ******************************************************************
  // Reference models
  // ******************************************************************

  // Inputs change and outputs are read 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Serial x^n + x^(n-1) + 1 stream, first word all ones
  // Lane 0 holds the oldest 16 bits, oldest bit at the MSB
  function automatic dac_tpl_pkg::sample_t pn_model(input int n, input int word, input int lane);
    bit stream [0:2047];
    dac_tpl_pkg::sample_t value;
    int base;
    base = word * WORD_BITS + lane * 16;
    for (int t = 0; t < base + 16; t++) begin
      stream[t] = (t < WORD_BITS) ? 1'b1 : stream[t-n] ^ stream[t-n+1];
    end
    for (int b = 0; b < 16; b++) begin
      value[15-b] = stream[base+b];
    end
    return value;
  endfunction

  // Sine from the top 10 phase bits, rounded
  function automatic int sine_model(input dac_tpl_pkg::phase_t phase);
    int idx;
    idx = int'(phase[15:6]);
    return int'(real'(dac_tpl_pkg::SINE_AMPL) * $sin(TWO_PI * real'(idx) / 1024.0));
  endfunction

  // Tone term of one lane, m words after the sync load
  function automatic longint tone_term(input dac_tpl_pkg::tone_cfg_t tone, input int lane,
                                       input int m);
    dac_tpl_pkg::phase_t phase;
    phase = dac_tpl_pkg::phase_t'(int'(tone.init) +
                                  (lane + m * DATA_PATH_WIDTH) * int'(tone.incr));
    return (longint'(sine_model(phase)) * longint'(tone.scale)) >>> 16;
  endfunction

  function automatic dac_tpl_pkg::sample_t dds_model(input dac_tpl_pkg::chan_cfg_t c,
                                                     input int lane, input int m,
                                                     input logic fmt);
    dac_tpl_pkg::sample_t sum;
    sum = dac_tpl_pkg::sample_t'(tone_term(c.tone_0, lane, m) + tone_term(c.tone_1, lane, m));
    // Offset binary flips the sign bit
    if (!fmt) sum[15] = ~sum[15];
    return sum;
  endfunction

  // ******************************************************************
  // Directed tests
  // ******************************************************************

  task automatic verify_reset_state();
    for (int k = 0; k < NUM_CHANNELS * DATA_PATH_WIDTH; k++) begin
      check_sample($sformatf("dac_data[%0d]", k), dac_data[k], '0);
    end
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      check_bit($sformatf("enable[%0d]", c), enable[c], 1'b0);
    end
  endtask

  // One channel streams DMA, the other sits at ZERO
  task automatic stream_dma_words(input int dma_chan);
    dac_tpl_pkg::sample_t [NUM_CHANNELS*DATA_PATH_WIDTH-1:0] sent;
    int other;
    other = 1 - dma_chan;
    cfg[dma_chan].sel = dac_tpl_pkg::DMA;
    cfg[other].sel    = dac_tpl_pkg::ZERO;
    for (int n = 0; n < DMA_CYCLES; n++) begin
      for (int k = 0; k < NUM_CHANNELS * DATA_PATH_WIDTH; k++) begin
        rng_state   = xorshift32(rng_state);
        dma_data[k] = rng_state[15:0];
      end
      sent = dma_data;
      next_cycle();
      compare_lanes(dma_chan, sent[dma_chan*DATA_PATH_WIDTH +: DATA_PATH_WIDTH]);
      compare_lanes(other, '0);
      check_bit($sformatf("enable[%0d]", dma_chan), enable[dma_chan], 1'b1);
      check_bit($sformatf("enable[%0d]", other), enable[other], 1'b0);
    end
  endtask

  // Even lanes pat_0, odd lanes pat_1
  task automatic expect_pattern(input int chan);
    dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] exp;
    for (int lane = 0; lane < DATA_PATH_WIDTH; lane++) begin
      exp[lane] = (lane % 2 == 0) ? cfg[chan].pat_0 : cfg[chan].pat_1;
    end
    compare_lanes(chan, exp);
  endtask

  task automatic walk_pattern_select();
    cfg[0].sel   = dac_tpl_pkg::PATTERN;
    cfg[0].pat_0 = 16'h1234;
    cfg[0].pat_1 = 16'habcd;
    cfg[1].sel   = dac_tpl_pkg::PATTERN;
    cfg[1].pat_0 = 16'ha5a5;
    cfg[1].pat_1 = 16'h5a5a;
    next_cycle();
    expect_pattern(0);
    expect_pattern(1);
    // New select holds off until the next edge
    cfg[0].sel = dac_tpl_pkg::ZERO;
    #1;
    expect_pattern(0);
    next_cycle();
    compare_lanes(0, '0);
    expect_pattern(1);
    cfg[0].sel   = dac_tpl_pkg::PATTERN;
    cfg[0].pat_0 = 16'h0f0f;
    next_cycle();
    expect_pattern(0);
  endtask

  // Channel 0 carries PN7, channel 1 PN15
  task automatic compare_pn_sequences(input logic inverted);
    dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] exp7;
    dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] exp15;
    if (inverted) begin
      cfg[0].sel = dac_tpl_pkg::PN7_INV;
      cfg[1].sel = dac_tpl_pkg::PN15_INV;
    end else begin
      cfg[0].sel = dac_tpl_pkg::PN7;
      cfg[1].sel = dac_tpl_pkg::PN15;
    end
    sync = 1'b1;
    next_cycle();
    sync = 1'b0;
    next_cycle();
    for (int w = 0; w < PN_CYCLES; w++) begin
      for (int lane = 0; lane < DATA_PATH_WIDTH; lane++) begin
        exp7[lane]  = inverted ? ~pn_model(7, w, lane) : pn_model(7, w, lane);
        exp15[lane] = inverted ? ~pn_model(15, w, lane) : pn_model(15, w, lane);
      end
      compare_lanes(0, exp7);
      compare_lanes(1, exp15);
      next_cycle();
    end
  endtask

  // Phases loaded by sync reach dac_data three edges later
  task automatic sweep_dds_tones(input logic fmt);
    dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] exp;
    dds_format = fmt;
    cfg[0].sel = dac_tpl_pkg::DDS;
    cfg[1].sel = dac_tpl_pkg::DDS;
    sync = 1'b1;
    next_cycle();
    sync = 1'b0;
    repeat (2) next_cycle();
    for (int m = 0; m < DDS_CYCLES; m++) begin
      next_cycle();
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        for (int lane = 0; lane < DATA_PATH_WIDTH; lane++) begin
          exp[lane] = dds_model(cfg[c], lane, m, fmt);
        end
        compare_lanes(c, exp);
      end
    end
  endtask

  // ******************************************************************
  // Test sequence
  // ******************************************************************

  initial begin
    rst         = 1'b1;
    sync        = 1'b0;
    dds_format  = 1'b1;
    cfg         = '0;
    cfg[0].sel  = dac_tpl_pkg::ZERO;
    cfg[1].sel  = dac_tpl_pkg::ZERO;
    dma_data    = '0;
    rng_state   = 32'hc03f;
    checks_done = 0;
    repeat (RESET_CYCLES) next_cycle();
    rst = 1'b0;
    verify_reset_state();
    stream_dma_words(0);
    stream_dma_words(1);
    walk_pattern_select();
    // Tones with distinct steps, channel 1 near full scale so the sum wraps
    cfg[0].tone_0 = '{scale: 16'h8000, init: 16'h1000, incr: 16'h0123};
    cfg[0].tone_1 = '{scale: 16'h4000, init: 16'h0000, incr: 16'h0a51};
    cfg[1].tone_0 = '{scale: 16'hffff, init: 16'h4321, incr: 16'h0777};
    cfg[1].tone_1 = '{scale: 16'hc000, init: 16'hc000, incr: 16'hf0e1};
    compare_pn_sequences(1'b0);
    compare_pn_sequences(1'b1);
    sweep_dds_tones(1'b1);
    sweep_dds_tones(1'b0);
    if (checks_done > 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_run("No checks were run");
    end
  end

endmodule

/* hdl/dac_tpl_core.sv */
// Top level of the DAC transmit transport layer.
// Runs NUM_CHANNELS channels side by side. Each channel takes its
// entry of cfg and its slice of DATA_PATH_WIDTH samples from dma_data,
// and drives the matching slice of dac_data and its enable bit.
// sync and dds_format are common to all channels.

`timescale 1ns/1ps

module dac_tpl_core #(
  parameter int NUM_CHANNELS    = 2,
  parameter int DATA_PATH_WIDTH = 4
) (
  input  logic                                                       clk,
  input  logic                                                       rst,
  input  logic                                                       sync,
  input  logic                                                       dds_format,
  input  dac_tpl_pkg::chan_cfg_t [NUM_CHANNELS-1:0]                  cfg,
  input  dac_tpl_pkg::sample_t [NUM_CHANNELS*DATA_PATH_WIDTH-1:0]    dma_data,
  output dac_tpl_pkg::sample_t [NUM_CHANNELS*DATA_PATH_WIDTH-1:0]    dac_data,
  output logic [NUM_CHANNELS-1:0]                                    enable
);

  // ********************************************************************
  // One channel per configuration entry
  // ********************************************************************

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_channel
    // Channel c owns samples c*DATA_PATH_WIDTH and up
    dac_channel #(
      .DATA_PATH_WIDTH (DATA_PATH_WIDTH)
    ) dac_channel_inst (
      .clk        (clk),
      .rst        (rst),
      .sync       (sync),
      .dds_format (dds_format),
      .cfg        (cfg[c]),
      .dma_data   (dma_data[c*DATA_PATH_WIDTH +: DATA_PATH_WIDTH]),
      .dac_data   (dac_data[c*DATA_PATH_WIDTH +: DATA_PATH_WIDTH]),
      .enable     (enable[c])
    );
  end

endmodule

/* hdl/dac_channel.sv */
// One DAC channel of the transport layer.
// Holds the per-lane DDS phase accumulators, the PN generators and
// the output select register. dac_data and enable follow sel,
// dma_data and the pattern words one clock later.

`timescale 1ns/1ps

module dac_channel #(
  parameter int DATA_PATH_WIDTH = 4
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        sync,
  input  logic                                        dds_format,
  input  dac_tpl_pkg::chan_cfg_t                      cfg,
  input  dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0]  dma_data,
  output dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0]  dac_data,
  output logic                                        enable
);

  dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] pn7;
  dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] pn15;
  dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] dds_data;
  dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0] pattern;

  // ********************************************************************
  // PN sources
  // ********************************************************************

  pn_source #(
    .DATA_PATH_WIDTH (DATA_PATH_WIDTH)
  ) pn_source_inst (
    .clk  (clk),
    .rst  (rst),
    .sync (sync),
    .pn7  (pn7),
    .pn15 (pn15)
  );

  // ********************************************************************
  // DDS phase step of one word of lanes per clock
  // ********************************************************************

  dac_tpl_pkg::phase_t step_0;
  dac_tpl_pkg::phase_t step_1;

  always_ff @(posedge clk) begin
    if (rst) begin
      step_0 <= '0;
      step_1 <= '0;
    end else if (sync) begin
      // Latched so a config change mid-run cannot tear the lanes apart
      step_0 <= cfg.tone_0.incr * dac_tpl_pkg::phase_t'(DATA_PATH_WIDTH);
      step_1 <= cfg.tone_1.incr * dac_tpl_pkg::phase_t'(DATA_PATH_WIDTH);
    end
  end

  // Per-lane phase accumulators, DDS and pattern word
  for (genvar i = 0; i < DATA_PATH_WIDTH; i++) begin : g_lane
    localparam dac_tpl_pkg::phase_t LANE = dac_tpl_pkg::phase_t'(i);

    dac_tpl_pkg::phase_t phase_0;
    dac_tpl_pkg::phase_t phase_1;

    // Sync places lane i at init + i * incr
    always_ff @(posedge clk) begin
      if (rst) begin
        phase_0 <= '0;
        phase_1 <= '0;
      end else if (sync) begin
        phase_0 <= cfg.tone_0.init + cfg.tone_0.incr * LANE;
        phase_1 <= cfg.tone_1.init + cfg.tone_1.incr * LANE;
      end else begin
        phase_0 <= phase_0 + step_0;
        phase_1 <= phase_1 + step_1;
      end
    end

    dds_two_tone dds_two_tone_inst (
      .clk     (clk),
      .format  (dds_format),
      .phase_0 (phase_0),
      .phase_1 (phase_1),
      .scale_0 (cfg.tone_0.scale),
      .scale_1 (cfg.tone_1.scale),
      .sample  (dds_data[i])
    );

    // Even lanes carry pat_0 and odd lanes pat_1
    assign pattern[i] = (i % 2 == 0) ? cfg.pat_0 : cfg.pat_1;
  end

  // ********************************************************************
  // Source select register
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      dac_data <= '0;
      enable   <= 1'b0;
    end else begin
      enable <= (cfg.sel == dac_tpl_pkg::DMA);
      case (cfg.sel)
        dac_tpl_pkg::PN15:     dac_data <= pn15;
        dac_tpl_pkg::PN7:      dac_data <= pn7;
        dac_tpl_pkg::PN15_INV: dac_data <= ~pn15;
        dac_tpl_pkg::PN7_INV:  dac_data <= ~pn7;
        dac_tpl_pkg::ZERO:     dac_data <= '0;
        dac_tpl_pkg::DMA:      dac_data <= dma_data;
        dac_tpl_pkg::PATTERN:  dac_data <= pattern;
        default:               dac_data <= dds_data;
      endcase
    end
  end

  // DMA request only for a channel that was selecting DMA
  // and is passing the DMA words through to its lanes
  a_enable_dma: assert property (@(posedge clk) disable iff (rst)
    enable |-> ($past(cfg.sel) == dac_tpl_pkg::DMA) && (dac_data == $past(dma_data)));

endmodule

/* hdl/pn_source.sv */
// PN7 and PN15 test sequence generators.
// Each clock the sequences advance by a whole word of DATA_PATH_WIDTH
// samples. Sync (or reset) reloads both with all ones. The lane order
// is reversed on the way out so lane 0 carries the oldest sample.

`timescale 1ns/1ps

module pn_source #(
  parameter int DATA_PATH_WIDTH = 4
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        sync,
  output dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0]  pn7,
  output dac_tpl_pkg::sample_t [DATA_PATH_WIDTH-1:0]  pn15
);

  localparam int DW = DATA_PATH_WIDTH * 16;

  // Next word of an x^n + x^(n-1) + 1 sequence, n up to 15
  // Bits are filled from the top, each from the n and n-1 bits above
  function automatic logic [DW-1:0] lfsr_next(input logic [DW-1:0] state, input int n);
    logic [DW+14:0] full;
    full = '0;
    for (int j = 0; j < n; j++) begin
      full[DW+j] = state[j];
    end
    for (int k = DW - 1; k >= 0; k--) begin
      full[k] = full[k+n] ^ full[k+n-1];
    end
    return full[DW-1:0];
  endfunction

  logic [DW-1:0] pn7_state;
  logic [DW-1:0] pn15_state;

  // Seed on reset and sync, otherwise a full word step
  always_ff @(posedge clk) begin
    if (rst || sync) begin
      pn7_state  <= '1;
      pn15_state <= '1;
    end else begin
      pn7_state  <= lfsr_next(pn7_state, 7);
      pn15_state <= lfsr_next(pn15_state, 15);
    end
  end

  // Swizzle, highest state slice is the oldest sample
  for (genvar i = 0; i < DATA_PATH_WIDTH; i++) begin : g_swizzle
    assign pn7[DATA_PATH_WIDTH-1-i]  = pn7_state[i*16 +: 16];
    assign pn15[DATA_PATH_WIDTH-1-i] = pn15_state[i*16 +: 16];
  end

  // An all-zero state would lock the generator
  a_pn15_alive: assert property (@(posedge clk) disable iff (rst) pn15_state != '0);

endmodule

/* hdl/dds_two_tone.sv */
// Two-tone DDS for one sample lane.
// Two sine lookups are each scaled by a Q0.16 amplitude and summed.
// The sum leaves as two's complement or offset binary, picked by format.
// Latency is two clocks: table lookup, then scale and sum.

`timescale 1ns/1ps

module dds_two_tone (
  input  logic                 clk,
  input  logic                 format,
  input  dac_tpl_pkg::phase_t  phase_0,
  input  dac_tpl_pkg::phase_t  phase_1,
  input  dac_tpl_pkg::scale_t  scale_0,
  input  dac_tpl_pkg::scale_t  scale_1,
  output dac_tpl_pkg::sample_t sample
);

  // Raw sines from the two tables
  dac_tpl_pkg::sample_t sine_0;
  dac_tpl_pkg::sample_t sine_1;

  // ********************************************************************
  // Lookup stage
  // ********************************************************************

  dds_sine_rom dds_sine_rom_0_inst (
    .clk   (clk),
    .phase (phase_0),
    .ampl  (sine_0)
  );

  dds_sine_rom dds_sine_rom_1_inst (
    .clk   (clk),
    .phase (phase_1),
    .ampl  (sine_1)
  );

  // ********************************************************************
  // Scale and sum stage
  // ********************************************************************

  // Signed sine times unsigned scale, scale gets a zero sign bit
  logic signed [32:0] prod_0;
  logic signed [32:0] prod_1;
  dac_tpl_pkg::sample_t term_0;
  dac_tpl_pkg::sample_t term_1;
  dac_tpl_pkg::sample_t sum;

  assign prod_0 = $signed(sine_0) * $signed({1'b0, scale_0});
  assign prod_1 = $signed(sine_1) * $signed({1'b0, scale_1});

  // Drop the Q0.16 fraction, result fits in one sample word
  assign term_0 = dac_tpl_pkg::sample_t'(prod_0 >>> 16);
  assign term_1 = dac_tpl_pkg::sample_t'(prod_1 >>> 16);

  // Tones add modulo the word width
  assign sum = term_0 + term_1;

  // Format low flips the sign bit for offset binary
  always_ff @(posedge clk) begin
    sample <= {sum[15] ^ ~format, sum[14:0]};
  end

endmodule

/* hdl/dds_sine_rom.sv */
// Sine lookup for the DDS.
// Takes the top 10 bits of a 16-bit phase and returns a signed sample
// one clock later. Only a quarter wave is stored; the other three
// quadrants come from mirroring the index and negating the result.

`timescale 1ns/1ps

module dds_sine_rom (
  input  logic                 clk,
  input  dac_tpl_pkg::phase_t  phase,
  output dac_tpl_pkg::sample_t ampl
);

  localparam real TWO_PI = 6.283185307179586;

  // ********************************************************************
  // Quarter-wave table, 256 entries of round(peak * sin(2*pi*k/1024))
  // ********************************************************************

  dac_tpl_pkg::sample_t quarter [256];

  initial begin
    for (int k = 0; k < 256; k++) begin
      // int' cast rounds to nearest
      quarter[k] = dac_tpl_pkg::sample_t'(
        int'(real'(dac_tpl_pkg::SINE_AMPL) * $sin(TWO_PI * real'(k) / 1024.0)));
    end
  end

  // Quadrant and index within the quadrant
  logic [1:0] quadrant;
  logic [7:0] index;
  logic [7:0] mirror;
  dac_tpl_pkg::sample_t magnitude;

  assign quadrant = phase[15:14];
  assign index    = phase[13:6];

  // 256 - index, wraps to 0 for index 0 which is handled as the peak
  assign mirror = ~index + 8'd1;

  always_comb begin
    if (!quadrant[0]) begin
      // Rising side of the quadrant
      magnitude = quarter[index];
    end else if (index == 8'd0) begin
      // Exactly a quarter cycle, beyond the stored table
      magnitude = dac_tpl_pkg::sample_t'(dac_tpl_pkg::SINE_AMPL);
    end else begin
      // Falling side, read the table backwards
      magnitude = quarter[mirror];
    end
  end

  // Second half of the cycle is negative
  always_ff @(posedge clk) begin
    if (quadrant[1]) begin
      ampl <= -magnitude;
    end else begin
      ampl <= magnitude;
    end
  end

endmodule

/* hdl/dac_tpl_pkg.sv */
// Shared types for the DAC transmit transport layer.
// Sample, phase and scale widths, the source select codes and the
// per-channel configuration struct that the top level fans out.
// Modules refer to these by scoped names.

package dac_tpl_pkg;

  // ********************************************************************
  // Widths with a meaning
  // ********************************************************************

  // One DAC sample word
  typedef logic [15:0] sample_t;

  // DDS phase, full cycle is 65536
  typedef logic [15:0] phase_t;

  // Unsigned Q0.16 tone amplitude
  typedef logic [15:0] scale_t;

  // Peak of the sine table
  localparam int SINE_AMPL = 32767;

  // ********************************************************************
  // Source select, unlisted codes fall back to DDS
  // ********************************************************************

  typedef enum logic [3:0] {
    DDS      = 4'd0,
    PATTERN  = 4'd1,
    DMA      = 4'd2,
    ZERO     = 4'd3,
    PN7_INV  = 4'd4,
    PN15_INV = 4'd5,
    PN7      = 4'd6,
    PN15     = 4'd7
  } src_sel_e;

  // One tone of the two-tone DDS
  typedef struct packed {
    scale_t scale;
    phase_t init;
    phase_t incr;
  } tone_cfg_t;

  // Everything one channel needs
  typedef struct packed {
    src_sel_e  sel;
    tone_cfg_t tone_0;
    tone_cfg_t tone_1;
    sample_t   pat_0;
    sample_t   pat_1;
  } chan_cfg_t;

endpackage
